// ==== src/rs_defs.svh ====
`ifndef RS_DEFS_SVH
`define RS_DEFS_SVH

// Active stations, 1 to 3
`define RS_NSTATION 3
// Physical station slots built in hardware
`define RS_NSLOT 3
// Dispatch lanes presented per cycle
`define RS_NLANE 2

`define RS_VAL_W 32
`define RS_PREG_W 5
`define RS_PREG_N 32
`define RS_OP_W 6
`define RS_FU_W 4
`define RS_ROB_N 16
`define RS_RNDX_W 4
`define RS_LFSR_W 17

`define RS_NOP 6'd0

`endif

// ==== src/rs_pkg.sv ====
`include "rs_defs.svh"

package rs_pkg;

	// ====================
	// Scalar types
	// ====================

	typedef logic [`RS_VAL_W-1:0] value_t;
	typedef logic [`RS_PREG_W-1:0] preg_t;
	typedef logic [`RS_RNDX_W-1:0] rndx_t;
	typedef logic [`RS_OP_W-1:0] opcode_t;
	typedef logic [`RS_FU_W-1:0] fu_t;

	// ====================
	// Operand word
	// ====================

	// The paired valid bit selects the view.
	// Valid means the word holds the value itself, otherwise
	// the low bits name the physical register still being produced
	typedef union packed {
		value_t val;
		struct packed {
			logic [`RS_VAL_W-`RS_PREG_W-1:0] pad;
			preg_t preg;
		} rv;
	} operand_u;

endpackage

// ==== src/rs_lfsr.sv ====
`timescale 1ns/1ps
`include "rs_defs.svh"

module rs_lfsr (
	input  logic clk,
	input  logic rst,
	output logic [`RS_LFSR_W-1:0] lfsr_o
);

	// Any nonzero seed works, the all-zero state would lock up
	localparam logic [`RS_LFSR_W-1:0] SEED = `RS_LFSR_W'h1;

	logic feedback;

	// Taps for x^17 + x^14 + 1 give the full 2^17-1 sequence
	assign feedback = lfsr_o[16] ^ lfsr_o[13];

	always_ff @(posedge clk) begin
		if (rst) begin
			lfsr_o <= SEED;
		end else begin
			lfsr_o <= {lfsr_o[`RS_LFSR_W-2:0], feedback};
		end
	end

endmodule

// ==== src/rs_phys_regfile.sv ====
`timescale 1ns/1ps
`include "rs_defs.svh"

module rs_phys_regfile (
	input  logic clk,
	input  logic rst,
	input  logic wb_v_i,
	input  rs_pkg::preg_t wb_preg_i,
	input  rs_pkg::value_t wb_val_i,
	input  logic alloc_v_i,
	input  rs_pkg::preg_t alloc_dst_i,
	input  logic [1:0] rd_req_i,
	input  rs_pkg::preg_t rd_preg_i [2],
	output rs_pkg::value_t rd_val_o [2],
	output logic [1:0] rd_ok_o
);

	rs_pkg::value_t rf_val [`RS_PREG_N];
	logic [`RS_PREG_N-1:0] rf_ok;

	// ====================
	// Write side
	// ====================

	// Every register starts out valid and zero.
	// Write-back comes last so it wins over a clear on the same register
	always_ff @(posedge clk) begin
		if (rst) begin
			rf_ok <= '1;
			for (int r = 0; r < `RS_PREG_N; r++) begin
				rf_val[r] <= '0;
			end
		end else begin
			if (alloc_v_i) begin
				rf_ok[alloc_dst_i] <= 1'b0;
			end
			if (wb_v_i) begin
				rf_ok[wb_preg_i] <= 1'b1;
				rf_val[wb_preg_i] <= wb_val_i;
			end
		end
	end

	// ====================
	// Read side
	// ====================

	always_comb begin
		for (int k = 0; k < 2; k++) begin
			rd_val_o[k] = rf_val[rd_preg_i[k]];
			rd_ok_o[k] = rd_req_i[k] & rf_ok[rd_preg_i[k]];
		end
	end

	// Rename never hands out a register whose result is arriving now
	a_no_alloc_wb_clash: assert property (@(posedge clk) disable iff (rst)
		!(alloc_v_i && wb_v_i && alloc_dst_i == wb_preg_i));

endmodule

// ==== src/rs_read_request.sv ====
`timescale 1ns/1ps
`include "rs_defs.svh"

module rs_read_request (
	input  logic [`RS_NSLOT-1:0] st_busy_i,
	input  logic [`RS_NSLOT-1:0] st_a_v_i,
	input  rs_pkg::operand_u st_a_i [`RS_NSLOT],
	input  logic [`RS_NSLOT-1:0] st_b_v_i,
	input  rs_pkg::operand_u st_b_i [`RS_NSLOT],
	output logic [1:0] rd_req_o,
	output rs_pkg::preg_t rd_preg_o [2]
);

	// Stations are walked in order, operand A ahead of B.
	// Only the first two pending operands get a read port this cycle
	always_comb begin
		int k;
		k = 0;
		rd_req_o = '0;
		rd_preg_o[0] = '0;
		rd_preg_o[1] = '0;
		for (int s = 0; s < `RS_NSLOT; s++) begin
			if (st_busy_i[s] && !st_a_v_i[s] && k < 2) begin
				rd_req_o[k] = 1'b1;
				rd_preg_o[k] = st_a_i[s].rv.preg;
				k = k + 1;
			end
			if (st_busy_i[s] && !st_b_v_i[s] && k < 2) begin
				rd_req_o[k] = 1'b1;
				rd_preg_o[k] = st_b_i[s].rv.preg;
				k = k + 1;
			end
		end
	end

endmodule

// ==== src/rs_operand_capture.sv ====
`timescale 1ns/1ps
`include "rs_defs.svh"

module rs_operand_capture (
	input  logic [`RS_NSLOT-1:0] st_busy_i,
	input  logic [`RS_NSLOT-1:0] st_v_i,
	input  rs_pkg::operand_u st_opnd_i [`RS_NSLOT],
	input  logic wb_v_i,
	input  rs_pkg::preg_t wb_preg_i,
	input  rs_pkg::value_t wb_val_i,
	input  logic [1:0] rd_ok_i,
	input  rs_pkg::preg_t rd_preg_i [2],
	input  rs_pkg::value_t rd_val_i [2],
	output logic [`RS_NSLOT-1:0] hit_o,
	output rs_pkg::value_t hit_val_o [`RS_NSLOT]
);

	// ====================
	// Match per station
	// ====================

	// A pending slot carries a register number in its low bits.
	// The write-back bus is checked first since the register file
	// only sees that value after this edge
	always_comb begin
		rs_pkg::preg_t want;
		logic pending;
		for (int s = 0; s < `RS_NSLOT; s++) begin
			want = st_opnd_i[s].rv.preg;
			pending = st_busy_i[s] & ~st_v_i[s];
			hit_o[s] = 1'b0;
			hit_val_o[s] = wb_val_i;
			if (pending) begin
				if (wb_v_i && wb_preg_i == want) begin
					hit_o[s] = 1'b1;
					hit_val_o[s] = wb_val_i;
				end else if (rd_ok_i[0] && rd_preg_i[0] == want) begin
					hit_o[s] = 1'b1;
					hit_val_o[s] = rd_val_i[0];
				end else if (rd_ok_i[1] && rd_preg_i[1] == want) begin
					hit_o[s] = 1'b1;
					hit_val_o[s] = rd_val_i[1];
				end
			end
		end
	end

endmodule

// ==== src/rs_station_ctrl.sv ====
`timescale 1ns/1ps
`include "rs_defs.svh"

module rs_station_ctrl #(
	parameter rs_pkg::fu_t FUNCUNIT = 4'd0
) (
	input  logic clk,
	input  logic rst,
	input  logic available_i,
	input  logic [`RS_NLANE-1:0] disp_v_i,
	input  rs_pkg::fu_t disp_fu_i [`RS_NLANE],
	input  rs_pkg::opcode_t disp_op_i [`RS_NLANE],
	input  rs_pkg::rndx_t disp_rndx_i [`RS_NLANE],
	input  rs_pkg::preg_t disp_dst_i [`RS_NLANE],
	input  rs_pkg::operand_u disp_a_i [`RS_NLANE],
	input  logic [`RS_NLANE-1:0] disp_a_v_i,
	input  rs_pkg::operand_u disp_b_i [`RS_NLANE],
	input  logic [`RS_NLANE-1:0] disp_b_v_i,
	input  logic stall_i,
	input  logic [`RS_ROB_N-1:0] stomp_i,
	input  logic [`RS_NSLOT-1:0] hit_a_i,
	input  rs_pkg::value_t hit_a_val_i [`RS_NSLOT],
	input  logic [`RS_NSLOT-1:0] hit_b_i,
	input  rs_pkg::value_t hit_b_val_i [`RS_NSLOT],
	input  logic [`RS_LFSR_W-1:0] lfsr_i,
	output logic busy_o,
	output logic alloc_v_o,
	output rs_pkg::preg_t alloc_dst_o,
	output logic [`RS_NSLOT-1:0] st_busy_o,
	output logic [`RS_NSLOT-1:0] st_a_v_o,
	output rs_pkg::operand_u st_a_o [`RS_NSLOT],
	output logic [`RS_NSLOT-1:0] st_b_v_o,
	output rs_pkg::operand_u st_b_o [`RS_NSLOT],
	output logic issue_o,
	output rs_pkg::opcode_t iss_op_o,
	output rs_pkg::rndx_t iss_rndx_o,
	output rs_pkg::preg_t iss_dst_o,
	output rs_pkg::value_t iss_a_o,
	output rs_pkg::value_t iss_b_o
);

	// Slots at or above RS_NSTATION exist but are parked
	localparam logic [`RS_NSLOT-1:0] ACTIVE = `RS_NSLOT'((1 << `RS_NSTATION) - 1);

	logic [`RS_NSLOT-1:0] st_rdy;
	rs_pkg::opcode_t st_op [`RS_NSLOT];
	rs_pkg::rndx_t st_rndx [`RS_NSLOT];
	rs_pkg::preg_t st_dst [`RS_NSLOT];

	logic [`RS_NLANE-1:0] lane_hit;
	logic sel;
	logic accept;
	logic [`RS_NSLOT-1:0] load;
	logic pick_v;
	logic [1:0] pick;
	logic pick_stomp;
	logic stall_q;
	logic fire;

	// ====================
	// Dispatch
	// ====================

	always_comb begin
		for (int l = 0; l < `RS_NLANE; l++) begin
			lane_hit[l] = disp_v_i[l] && disp_fu_i[l] == FUNCUNIT;
		end
	end

	// Lane 0 has priority
	assign sel = ~lane_hit[0];
	assign busy_o = &(st_busy_o | ~ACTIVE);
	assign accept = available_i & (|lane_hit) & ~busy_o;
	assign alloc_v_o = accept;
	assign alloc_dst_o = disp_dst_i[sel];

	// Lowest free active slot takes the new entry
	always_comb begin
		load = '0;
		for (int s = 0; s < `RS_NSLOT; s++) begin
			if (accept && ACTIVE[s] && !st_busy_o[s] && load == '0)
				load[s] = 1'b1;
		end
	end

	// ====================
	// Issue select
	// ====================

	// One ready entry wins; ties go to the LFSR
	always_comb begin
		pick_v = 1'b1;
		pick = 2'd0;
		casez (st_rdy)
			3'b000: pick_v = 1'b0;
			3'b001: pick = 2'd0;
			3'b010: pick = 2'd1;
			3'b100: pick = 2'd2;
			3'b011: pick = lfsr_i[0] ? 2'd1 : 2'd0;
			3'b101: pick = lfsr_i[0] ? 2'd2 : 2'd0;
			3'b110: pick = lfsr_i[0] ? 2'd2 : 2'd1;
			default: begin
				if (lfsr_i[3:0] < 4'd5)
					pick = 2'd0;
				else if (lfsr_i[3:0] < 4'd10)
					pick = 2'd1;
				else
					pick = 2'd2;
			end
		endcase
	end

	assign pick_stomp = stomp_i[st_rndx[pick]];
	// The first cycle after a stall drops is left empty
	assign fire = pick_v & ~stall_i & ~stall_q;

	// ====================
	// Station control state
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			st_busy_o <= '0;
			st_rdy <= '0;
			st_a_v_o <= '0;
			st_b_v_o <= '0;
			stall_q <= 1'b0;
			issue_o <= 1'b0;
		end else begin
			issue_o <= 1'b0;
			stall_q <= stall_i;
			for (int s = 0; s < `RS_NSLOT; s++) begin
				// Ready lags the operand valids by one edge
				st_rdy[s] <= st_busy_o[s] & st_a_v_o[s] & st_b_v_o[s];
				if (hit_a_i[s])
					st_a_v_o[s] <= 1'b1;
				if (hit_b_i[s])
					st_b_v_o[s] <= 1'b1;
				if (load[s]) begin
					st_busy_o[s] <= 1'b1;
					st_rdy[s] <= disp_a_v_i[sel] & disp_b_v_i[sel];
					st_a_v_o[s] <= disp_a_v_i[sel];
					st_b_v_o[s] <= disp_b_v_i[sel];
				end
			end
			// A stomped pick is simply dropped here
			if (fire) begin
				issue_o <= ~pick_stomp;
				st_busy_o[pick] <= 1'b0;
				st_rdy[pick] <= 1'b0;
			end
			for (int s = 0; s < `RS_NSLOT; s++) begin
				if (!ACTIVE[s]) begin
					st_busy_o[s] <= 1'b1;
					st_rdy[s] <= 1'b0;
					st_a_v_o[s] <= 1'b1;
					st_b_v_o[s] <= 1'b1;
				end
			end
		end
	end

	// ====================
	// Station payload
	// ====================

	always_ff @(posedge clk) begin
		for (int s = 0; s < `RS_NSLOT; s++) begin
			if (hit_a_i[s])
				st_a_o[s].val <= hit_a_val_i[s];
			if (hit_b_i[s])
				st_b_o[s].val <= hit_b_val_i[s];
			if (load[s]) begin
				st_a_o[s] <= disp_a_i[sel];
				st_b_o[s] <= disp_b_i[sel];
				st_op[s] <= disp_op_i[sel];
				st_rndx[s] <= disp_rndx_i[sel];
				st_dst[s] <= disp_dst_i[sel];
			end
		end
		if (fire) begin
			iss_op_o <= pick_stomp ? `RS_NOP : st_op[pick];
			iss_rndx_o <= st_rndx[pick];
			iss_dst_o <= st_dst[pick];
			iss_a_o <= st_a_o[pick].val;
			iss_b_o <= st_b_o[pick].val;
		end
	end

	// The cycle after a stall drops never carries an issue
	a_no_issue_after_stall: assert property (@(posedge clk) disable iff (rst)
		$past(stall_i) |=> !issue_o);

	// A ready station always holds both operands
	a_rdy_has_operands: assert property (@(posedge clk) disable iff (rst)
		(st_rdy & ~(st_busy_o & st_a_v_o & st_b_v_o)) == '0);

endmodule

// ==== src/rs_top.sv ====
`timescale 1ns/1ps
`include "rs_defs.svh"

module rs_top #(
	parameter rs_pkg::fu_t FUNCUNIT = 4'd0
) (
	input  logic clk,
	input  logic rst,
	input  logic available_i,
	input  logic [`RS_NLANE-1:0] disp_v_i,
	input  rs_pkg::fu_t disp_fu_i [`RS_NLANE],
	input  rs_pkg::opcode_t disp_op_i [`RS_NLANE],
	input  rs_pkg::rndx_t disp_rndx_i [`RS_NLANE],
	input  rs_pkg::preg_t disp_dst_i [`RS_NLANE],
	input  rs_pkg::operand_u disp_a_i [`RS_NLANE],
	input  logic [`RS_NLANE-1:0] disp_a_v_i,
	input  rs_pkg::operand_u disp_b_i [`RS_NLANE],
	input  logic [`RS_NLANE-1:0] disp_b_v_i,
	input  logic wb_v_i,
	input  rs_pkg::preg_t wb_preg_i,
	input  rs_pkg::value_t wb_val_i,
	input  logic stall_i,
	input  logic [`RS_ROB_N-1:0] stomp_i,
	output logic busy_o,
	output logic issue_o,
	output rs_pkg::opcode_t iss_op_o,
	output rs_pkg::rndx_t iss_rndx_o,
	output rs_pkg::preg_t iss_dst_o,
	output rs_pkg::value_t iss_a_o,
	output rs_pkg::value_t iss_b_o
);

	logic [`RS_NSLOT-1:0] st_busy;
	logic [`RS_NSLOT-1:0] st_a_v;
	logic [`RS_NSLOT-1:0] st_b_v;
	rs_pkg::operand_u st_a [`RS_NSLOT];
	rs_pkg::operand_u st_b [`RS_NSLOT];
	logic [`RS_NSLOT-1:0] hit_a;
	logic [`RS_NSLOT-1:0] hit_b;
	rs_pkg::value_t hit_a_val [`RS_NSLOT];
	rs_pkg::value_t hit_b_val [`RS_NSLOT];
	logic [1:0] rd_req;
	logic [1:0] rd_ok;
	rs_pkg::preg_t rd_preg [2];
	rs_pkg::value_t rd_val [2];
	logic alloc_v;
	rs_pkg::preg_t alloc_dst;
	logic [`RS_LFSR_W-1:0] lfsr;

	rs_station_ctrl #(
		.FUNCUNIT(FUNCUNIT)
	) u_ctrl (
		.clk(clk), .rst(rst), .available_i(available_i),
		.disp_v_i(disp_v_i), .disp_fu_i(disp_fu_i), .disp_op_i(disp_op_i),
		.disp_rndx_i(disp_rndx_i), .disp_dst_i(disp_dst_i),
		.disp_a_i(disp_a_i), .disp_a_v_i(disp_a_v_i),
		.disp_b_i(disp_b_i), .disp_b_v_i(disp_b_v_i),
		.stall_i(stall_i), .stomp_i(stomp_i),
		.hit_a_i(hit_a), .hit_a_val_i(hit_a_val),
		.hit_b_i(hit_b), .hit_b_val_i(hit_b_val),
		.lfsr_i(lfsr), .busy_o(busy_o),
		.alloc_v_o(alloc_v), .alloc_dst_o(alloc_dst),
		.st_busy_o(st_busy), .st_a_v_o(st_a_v), .st_a_o(st_a),
		.st_b_v_o(st_b_v), .st_b_o(st_b),
		.issue_o(issue_o), .iss_op_o(iss_op_o), .iss_rndx_o(iss_rndx_o),
		.iss_dst_o(iss_dst_o), .iss_a_o(iss_a_o), .iss_b_o(iss_b_o)
	);

	rs_phys_regfile u_regfile (
		.clk(clk), .rst(rst),
		.wb_v_i(wb_v_i), .wb_preg_i(wb_preg_i), .wb_val_i(wb_val_i),
		.alloc_v_i(alloc_v), .alloc_dst_i(alloc_dst),
		.rd_req_i(rd_req), .rd_preg_i(rd_preg),
		.rd_val_o(rd_val), .rd_ok_o(rd_ok)
	);

	rs_read_request u_rdreq (
		.st_busy_i(st_busy),
		.st_a_v_i(st_a_v), .st_a_i(st_a),
		.st_b_v_i(st_b_v), .st_b_i(st_b),
		.rd_req_o(rd_req), .rd_preg_o(rd_preg)
	);

	rs_lfsr u_lfsr (
		.clk(clk), .rst(rst), .lfsr_o(lfsr)
	);

	// Same capture logic serves both source slots
	rs_operand_capture u_cap_a (
		.st_busy_i(st_busy), .st_v_i(st_a_v), .st_opnd_i(st_a),
		.wb_v_i(wb_v_i), .wb_preg_i(wb_preg_i), .wb_val_i(wb_val_i),
		.rd_ok_i(rd_ok), .rd_preg_i(rd_preg), .rd_val_i(rd_val),
		.hit_o(hit_a), .hit_val_o(hit_a_val)
	);

	rs_operand_capture u_cap_b (
		.st_busy_i(st_busy), .st_v_i(st_b_v), .st_opnd_i(st_b),
		.wb_v_i(wb_v_i), .wb_preg_i(wb_preg_i), .wb_val_i(wb_val_i),
		.rd_ok_i(rd_ok), .rd_preg_i(rd_preg), .rd_val_i(rd_val),
		.hit_o(hit_b), .hit_val_o(hit_b_val)
	);

endmodule

// ==== tb/rs_top_tb.sv ====
`timescale 1ns/1ps
`include "rs_defs.svh"

module rs_top_tb;

	localparam int N_OPS = 17;
	localparam int LIMIT = 30 * N_OPS + 100;
	localparam rs_pkg::fu_t MY_FU = 4'd3;
	localparam rs_pkg::fu_t OTHER_FU = 4'd5;
	// ROB index 15 is kept for lanes that must never be taken
	localparam rs_pkg::rndx_t JUNK_RNDX = 4'd15;

	logic clk;
	logic rst;
	logic available;
	logic [`RS_NLANE-1:0] disp_v;
	rs_pkg::fu_t disp_fu [`RS_NLANE];
	rs_pkg::opcode_t disp_op [`RS_NLANE];
	rs_pkg::rndx_t disp_rndx [`RS_NLANE];
	rs_pkg::preg_t disp_dst [`RS_NLANE];
	rs_pkg::operand_u disp_a [`RS_NLANE];
	logic [`RS_NLANE-1:0] disp_a_v;
	rs_pkg::operand_u disp_b [`RS_NLANE];
	logic [`RS_NLANE-1:0] disp_b_v;
	logic wb_v;
	rs_pkg::preg_t wb_preg;
	rs_pkg::value_t wb_val;
	logic stall;
	logic [`RS_ROB_N-1:0] stomp;
	logic busy;
	logic issue;
	rs_pkg::opcode_t iss_op;
	rs_pkg::rndx_t iss_rndx;
	rs_pkg::preg_t iss_dst;
	rs_pkg::value_t iss_a;
	rs_pkg::value_t iss_b;

	// ====================
	// Reference state
	// ====================

	rs_pkg::value_t model_val [`RS_PREG_N];
	logic model_ok [`RS_PREG_N];
	logic live [`RS_ROB_N];
	logic stomped [`RS_ROB_N];
	rs_pkg::opcode_t ent_op [`RS_ROB_N];
	rs_pkg::preg_t ent_dst [`RS_ROB_N];
	rs_pkg::operand_u ent_a [`RS_ROB_N];
	logic ent_a_v [`RS_ROB_N];
	rs_pkg::operand_u ent_b [`RS_ROB_N];
	logic ent_b_v [`RS_ROB_N];
	rs_pkg::preg_t wb_preg_q [$];
	rs_pkg::value_t wb_val_q [$];
	int wb_due_q [$];
	int pending;
	int cycle;
	integer seed;
	rs_pkg::rndx_t next_rndx;
	rs_pkg::preg_t next_dst;

	rs_top #(
		.FUNCUNIT(MY_FU)
	) rs_top_i (
		.clk(clk), .rst(rst), .available_i(available),
		.disp_v_i(disp_v), .disp_fu_i(disp_fu), .disp_op_i(disp_op),
		.disp_rndx_i(disp_rndx), .disp_dst_i(disp_dst),
		.disp_a_i(disp_a), .disp_a_v_i(disp_a_v),
		.disp_b_i(disp_b), .disp_b_v_i(disp_b_v),
		.wb_v_i(wb_v), .wb_preg_i(wb_preg), .wb_val_i(wb_val),
		.stall_i(stall), .stomp_i(stomp), .busy_o(busy),
		.issue_o(issue), .iss_op_o(iss_op), .iss_rndx_o(iss_rndx),
		.iss_dst_o(iss_dst), .iss_a_o(iss_a), .iss_b_o(iss_b)
	);

	initial begin : clock_gen
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	function automatic rs_pkg::operand_u val_word(input rs_pkg::value_t v);
		rs_pkg::operand_u w;
		w.val = v;
		return w;
	endfunction

	function automatic rs_pkg::operand_u reg_word(input rs_pkg::preg_t p);
		rs_pkg::operand_u w;
		w.val = '0;
		w.rv.preg = p;
		return w;
	endfunction

	// A register operand must carry what the execution unit wrote back
	function automatic rs_pkg::value_t exp_operand(input rs_pkg::operand_u w, input logic v);
		if (v)
			return w.val;
		return model_val[w.rv.preg];
	endfunction

	task automatic check_equal(input logic [31:0] got, input logic [31:0] want,
			input string what);
		if (got !== want) begin
			$display("** Error at %0t ns: %s, got %0h expected %0h", $time, what, got, want);
			$display("TB FAILED");
			$fatal(1, "Value mismatch");
		end
	endtask

	// Called and returns just after a rising edge
	task automatic dispatch_op(input int lane, input bit junk, input rs_pkg::opcode_t op,
			input rs_pkg::operand_u a, input logic a_v, input rs_pkg::operand_u b,
			input logic b_v, output rs_pkg::rndx_t r, output rs_pkg::preg_t d);
		int other;
		other = 1 - lane;
		r = next_rndx;
		d = next_dst;
		check_equal(32'(live[r]), 32'd0, "ROB index reused while live");
		while (busy) begin
			@(posedge clk);
			#2;
		end
		disp_v = '0;
		disp_v[lane] = 1'b1;
		disp_fu[lane] = MY_FU;
		disp_op[lane] = op;
		disp_rndx[lane] = r;
		disp_dst[lane] = d;
		disp_a[lane] = a;
		disp_a_v[lane] = a_v;
		disp_b[lane] = b;
		disp_b_v[lane] = b_v;
		// The other lane carries an op for a different unit
		if (junk) begin
			disp_v[other] = 1'b1;
			disp_fu[other] = OTHER_FU;
			disp_op[other] = 6'h3f;
			disp_rndx[other] = JUNK_RNDX;
			disp_dst[other] = 5'd31;
			disp_a[other] = val_word($random(seed));
			disp_a_v[other] = 1'b1;
			disp_b[other] = val_word($random(seed));
			disp_b_v[other] = 1'b1;
		end
		@(posedge clk);
		live[r] = 1'b1;
		ent_op[r] = op;
		ent_dst[r] = d;
		ent_a[r] = a;
		ent_a_v[r] = a_v;
		ent_b[r] = b;
		ent_b_v[r] = b_v;
		model_ok[d] = 1'b0;
		if (!stomped[r])
			pending++;
		#2;
		disp_v = '0;
		next_rndx = (next_rndx == 4'd14) ? 4'd0 : next_rndx + 4'd1;
		next_dst = next_dst + 5'd1;
	endtask

	task automatic wait_idle();
		while (pending != 0 || wb_preg_q.size() != 0)
			@(negedge clk);
		@(posedge clk);
		#2;
	endtask

	task automatic stalled_cycles(input int n, input logic busy_exp);
		repeat (n) begin
			@(negedge clk);
			check_equal(32'(issue), 32'd0, "issue raised while stalled");
			check_equal(32'(busy), 32'(busy_exp), "busy level while stalled");
			@(posedge clk);
			#2;
		end
	endtask

	// ====================
	// Issue compare
	// ====================

	initial begin : compare_issue
		rs_pkg::rndx_t r;
		forever begin
			@(negedge clk);
			if (issue) begin
				r = iss_rndx;
				check_equal(32'(live[r]), 32'd1, "issue for a ROB index with no entry");
				check_equal(32'(stomped[r]), 32'd0, "stomped entry raised issue");
				check_equal(32'(iss_op), 32'(ent_op[r]), "issued opcode");
				check_equal(32'(iss_dst), 32'(ent_dst[r]), "issued destination");
				if (!ent_a_v[r])
					check_equal(32'(model_ok[ent_a[r].rv.preg]), 32'd1,
						"operand A issued before its write-back");
				if (!ent_b_v[r])
					check_equal(32'(model_ok[ent_b[r].rv.preg]), 32'd1,
						"operand B issued before its write-back");
				check_equal(iss_a, exp_operand(ent_a[r], ent_a_v[r]), "issued operand A");
				check_equal(iss_b, exp_operand(ent_b[r], ent_b_v[r]), "issued operand B");
				live[r] = 1'b0;
				pending--;
				wb_preg_q.push_back(ent_dst[r]);
				wb_val_q.push_back($random(seed));
				wb_due_q.push_back(cycle + 3 + ($random(seed) & 3));
			end
		end
	end

	// Execution unit writes each result back after a short latency
	initial begin : exec_unit
		forever begin
			@(posedge clk);
			#2;
			wb_v = 1'b0;
			if (wb_preg_q.size() != 0 && wb_due_q[0] <= cycle) begin
				wb_v = 1'b1;
				wb_preg = wb_preg_q.pop_front();
				wb_val = wb_val_q.pop_front();
				void'(wb_due_q.pop_front());
				model_val[wb_preg] = wb_val;
				model_ok[wb_preg] = 1'b1;
			end
		end
	end

	initial begin : watchdog
		cycle = 0;
		while (cycle < LIMIT) begin
			@(posedge clk);
			cycle++;
		end
		$display("Timeout: the run did not finish within %0d cycles", LIMIT);
		$display("TB FAILED");
		$fatal(1, "Timeout");
	end

	// ====================
	// Stimulus
	// ====================

	initial begin : stimulus
		rs_pkg::rndx_t r;
		rs_pkg::rndx_t sr;
		rs_pkg::preg_t d;
		rs_pkg::preg_t d0;
		rs_pkg::preg_t d1;
		rs_pkg::preg_t d2;
		seed = 70;
		rst = 1'b1;
		available = 1'b1;
		disp_v = '0;
		disp_a_v = '0;
		disp_b_v = '0;
		for (int l = 0; l < `RS_NLANE; l++) begin
			disp_fu[l] = '0;
			disp_op[l] = '0;
			disp_rndx[l] = '0;
			disp_dst[l] = '0;
			disp_a[l] = '0;
			disp_b[l] = '0;
		end
		wb_v = 1'b0;
		wb_preg = '0;
		wb_val = '0;
		stall = 1'b0;
		stomp = '0;
		for (int p = 0; p < `RS_PREG_N; p++) begin
			model_val[p] = '0;
			model_ok[p] = 1'b1;
		end
		for (int i = 0; i < `RS_ROB_N; i++) begin
			live[i] = 1'b0;
			stomped[i] = 1'b0;
		end
		pending = 0;
		next_rndx = '0;
		next_dst = 5'd1;
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b0;

		repeat (3) begin
			@(negedge clk);
			check_equal(32'(issue), 32'd0, "issue high after reset");
			check_equal(32'(busy), 32'd0, "busy high after reset");
			@(posedge clk);
			#2;
		end

		// Both operands ready, issue lands in the second cycle after dispatch
		dispatch_op(0, 1'b0, 6'h01, val_word($random(seed)), 1'b1,
			val_word($random(seed)), 1'b1, r, d0);
		@(negedge clk);
		check_equal(32'(issue), 32'd0, "issue one cycle after dispatch");
		@(negedge clk);
		check_equal(32'(issue), 32'd1, "no issue two cycles after dispatch");
		@(posedge clk);
		#2;
		for (int i = 0; i < 4; i++) begin
			dispatch_op(i % 2, i == 3, 6'(i + 2), val_word($random(seed)), 1'b1,
				val_word($random(seed)), 1'b1, r, d);
		end
		wait_idle();

		// Consumers wait on write-back of producers still in flight
		dispatch_op(0, 1'b0, 6'h10, val_word($random(seed)), 1'b1,
			val_word($random(seed)), 1'b1, r, d1);
		dispatch_op(1, 1'b0, 6'h11, val_word($random(seed)), 1'b1,
			val_word($random(seed)), 1'b1, r, d2);
		dispatch_op(0, 1'b1, 6'h12, reg_word(d1), 1'b0, val_word($random(seed)), 1'b1, r, d);
		dispatch_op(1, 1'b1, 6'h13, reg_word(d1), 1'b0, reg_word(d2), 1'b0, r, d);
		wait_idle();

		// Registers already written come through the read ports
		dispatch_op(0, 1'b0, 6'h20, reg_word(d1), 1'b0, reg_word(5'd0), 1'b0, r, d);
		dispatch_op(1, 1'b0, 6'h21, reg_word(d0), 1'b0, val_word($random(seed)), 1'b1, r, d);
		wait_idle();

		// ====================
		// Stomp under a full station set
		// ====================

		stall = 1'b1;
		@(posedge clk);
		#2;
		stomp = 16'd1 << next_rndx;
		stomped[next_rndx] = 1'b1;
		dispatch_op(0, 1'b0, 6'h30, val_word($random(seed)), 1'b1,
			val_word($random(seed)), 1'b1, sr, d);
		dispatch_op(0, 1'b0, 6'h31, val_word($random(seed)), 1'b1,
			val_word($random(seed)), 1'b1, r, d);
		dispatch_op(1, 1'b0, 6'h32, val_word($random(seed)), 1'b1,
			val_word($random(seed)), 1'b1, r, d);
		stalled_cycles(3, 1'b1);
		stall = 1'b0;
		wait_idle();
		repeat (4) @(posedge clk);
		#2;
		check_equal(32'(busy), 32'd0, "busy still high after stomp");
		live[sr] = 1'b0;
		stomped[sr] = 1'b0;
		stomp = '0;

		// Stall with lanes for other units mixed in
		stall = 1'b1;
		disp_v = 2'b11;
		disp_fu[0] = OTHER_FU;
		disp_fu[1] = 4'd7;
		disp_rndx[0] = JUNK_RNDX;
		disp_rndx[1] = JUNK_RNDX;
		disp_op[0] = 6'h3f;
		disp_op[1] = 6'h3f;
		@(posedge clk);
		#2;
		disp_v = '0;
		for (int i = 0; i < 3; i++) begin
			check_equal(32'(busy), 32'd0, "no free station before stalled dispatch");
			dispatch_op(i == 1 ? 0 : 1, 1'b1, 6'(40 + i), val_word($random(seed)), 1'b1,
				val_word($random(seed)), 1'b1, r, d);
		end
		stalled_cycles(4, 1'b1);
		stall = 1'b0;
		wait_idle();

		check_equal(32'(busy), 32'd0, "busy high after all entries issued");
		$display("TB PASSED");
		$finish;
	end

endmodule

// ==== rs_top.f ====
+incdir+src
src/rs_pkg.sv
src/rs_lfsr.sv
src/rs_phys_regfile.sv
src/rs_read_request.sv
src/rs_operand_capture.sv
src/rs_station_ctrl.sv
src/rs_top.sv
tb/rs_top_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f rs_top.f --top-module rs_top_tb -o rs_top_tb_sim

out=$(./obj_dir/rs_top_tb_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "TB PASSED"; then
	exit 0
fi
echo "Simulation did not report a pass"
exit 1
